//--- hdl/gemm_params.svh
/* Array size, datapath widths and control register map of the GEMM accelerator.
   Included by every RTL file and by the testbench. */
`ifndef GEMM_PARAMS_SVH
`define GEMM_PARAMS_SVH

// Array geometry, rows by columns
`define GEMM_WIDTH  4
`define GEMM_HEIGHT 4
`define GEMM_ROW_W  ((`GEMM_WIDTH > 1) ? $clog2(`GEMM_WIDTH) : 1)

// Datapath widths
`define GEMM_ELEM_W 8
`define GEMM_ACC_W  32
`define GEMM_K_W    8

// Control port and register map
`define GEMM_ADDR_W     2
`define GEMM_DATA_W     32
`define GEMM_REG_K      2'd0
`define GEMM_REG_TRIG   2'd1
`define GEMM_REG_STATUS 2'd2

`endif

//--- hdl/gemm_pkg.sv
/* Shared types of the GEMM accelerator: operand and accumulator words and the
   job phase. Referenced by scoped name from the RTL and the testbench. */
`default_nettype none

`include "gemm_params.svh"

package gemm_pkg;

  // Signed 8-bit operand element of X, W and Y
  typedef logic signed [`GEMM_ELEM_W-1:0] elem_t;

  // Accumulator and Z element, wraps modulo 2^32
  typedef logic signed [`GEMM_ACC_W-1:0] acc_t;

  // Job sequence
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    BIAS  = 2'd1,
    MAC   = 2'd2,
    DRAIN = 2'd3
  } phase_e;

endpackage

`default_nettype wire

//--- hdl/gemm_cfg_decoder.sv
/* Control register decoder and job scheduler. Takes K and trigger writes, answers
   status reads and steps a job through bias load, accumulation and drain. */
`timescale 1ns/1ps
`default_nettype none

`include "gemm_params.svh"

module gemm_cfg_decoder (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      ctrl_req_i,
  input  logic                      ctrl_we_i,
  input  logic [`GEMM_ADDR_W-1:0]   ctrl_addr_i,
  input  logic [`GEMM_DATA_W-1:0]   ctrl_wdata_i,
  output logic [`GEMM_DATA_W-1:0]   ctrl_rdata_o,
  output logic                      ctrl_rvalid_o,
  input  logic                      y_valid_i,
  input  logic                      x_valid_i,
  input  logic                      drain_done_i,
  output logic                      bias_we_o,
  output logic [`GEMM_ROW_W-1:0]    bias_row_o,
  output logic                      mac_en_o,
  output logic                      drain_start_o,
  output logic                      busy_o
);

  localparam int ROW_W = `GEMM_ROW_W;
  localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`GEMM_WIDTH - 1);

  gemm_pkg::phase_e        phase_q;
  logic [`GEMM_K_W-1:0]    k_q;
  logic [`GEMM_K_W-1:0]    depth_q;
  logic [ROW_W-1:0]        row_q;
  logic [7:0]              job_cnt_q;
  logic                    start_q;
  logic                    k_wr;
  logic                    trig;
  logic [`GEMM_DATA_W-1:0] status_w;

  assign busy_o = (phase_q != gemm_pkg::IDLE);

  // Writes only land while idle
  assign k_wr = ctrl_req_i & ctrl_we_i & (ctrl_addr_i == `GEMM_REG_K) & ~busy_o;
  assign trig = ctrl_req_i & ctrl_we_i & (ctrl_addr_i == `GEMM_REG_TRIG) & ~busy_o;

  // Host strobes only count in their own phase
  assign bias_we_o     = (phase_q == gemm_pkg::BIAS) & y_valid_i;
  assign mac_en_o      = (phase_q == gemm_pkg::MAC) & x_valid_i;
  assign bias_row_o    = row_q;
  assign drain_start_o = start_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      phase_q   <= gemm_pkg::IDLE;
      k_q       <= '0;
      depth_q   <= '0;
      row_q     <= '0;
      job_cnt_q <= '0;
      start_q   <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (k_wr) begin
        k_q <= ctrl_wdata_i[`GEMM_K_W-1:0];
      end
      case (phase_q)
        gemm_pkg::IDLE: if (trig) begin
          phase_q <= gemm_pkg::BIAS;
          row_q   <= '0;
        end
        gemm_pkg::BIAS: if (bias_we_o) begin
          row_q <= row_q + 1'b1;
          if (row_q == LAST_ROW) begin
            depth_q <= '0;
            // Zero depth goes straight to the drain
            if (k_q == '0) begin
              phase_q <= gemm_pkg::DRAIN;
              start_q <= 1'b1;
            end else begin
              phase_q <= gemm_pkg::MAC;
            end
          end
        end
        gemm_pkg::MAC: if (mac_en_o) begin
          depth_q <= depth_q + 1'b1;
          if ((depth_q + 1'b1) == k_q) begin
            phase_q <= gemm_pkg::DRAIN;
            start_q <= 1'b1;
          end
        end
        default: if (drain_done_i) begin
          phase_q   <= gemm_pkg::IDLE;
          job_cnt_q <= job_cnt_q + 1'b1;
        end
      endcase
    end
  end

  // Status word with busy in bit 0 and finished jobs in 15:8
  always_comb begin
    status_w       = '0;
    status_w[0]    = busy_o;
    status_w[15:8] = job_cnt_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_rvalid_o <= 1'b0;
    end else begin
      ctrl_rvalid_o <= ctrl_req_i & ~ctrl_we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    ctrl_rdata_o <= (ctrl_addr_i == `GEMM_REG_STATUS) ? status_w : '0;
  end

  // The array must never see a bias load and an accumulate in one cycle
  a_we_mac_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(bias_we_o && mac_en_o));

endmodule

`default_nettype wire

//--- hdl/gemm_mac_array.sv
/* Grid of signed accumulators. A bias write loads one row from Y, an accumulate
   step adds the outer product of the X and W vectors to every cell. */
`timescale 1ns/1ps
`default_nettype none

`include "gemm_params.svh"

module gemm_mac_array (
  input  logic                                                clk_i,
  input  logic                                                rst_i,
  input  logic                                                bias_we_i,
  input  logic [`GEMM_ROW_W-1:0]                              bias_row_i,
  input  gemm_pkg::elem_t [`GEMM_HEIGHT-1:0]                  y_row_i,
  input  logic                                                mac_en_i,
  input  gemm_pkg::elem_t [`GEMM_WIDTH-1:0]                   x_vec_i,
  input  gemm_pkg::elem_t [`GEMM_HEIGHT-1:0]                  w_vec_i,
  output gemm_pkg::acc_t  [`GEMM_WIDTH-1:0][`GEMM_HEIGHT-1:0] acc_o
);

  gemm_pkg::acc_t [`GEMM_WIDTH-1:0][`GEMM_HEIGHT-1:0] acc_q;

  // Every row is overwritten by its bias before accumulation starts
  always_ff @(posedge clk_i) begin
    if (bias_we_i) begin
      for (int c = 0; c < `GEMM_HEIGHT; c++) begin
        acc_q[bias_row_i][c] <= gemm_pkg::acc_t'($signed(y_row_i[c]));
      end
    end else if (mac_en_i) begin
      // One product per cell, all cells in parallel
      for (int r = 0; r < `GEMM_WIDTH; r++) begin
        for (int c = 0; c < `GEMM_HEIGHT; c++) begin
          acc_q[r][c] <= acc_q[r][c]
                       + gemm_pkg::acc_t'($signed(x_vec_i[r]))
                       * gemm_pkg::acc_t'($signed(w_vec_i[c]));
        end
      end
    end
  end

  assign acc_o = acc_q;

  // Row index from the scheduler stays inside the grid
  a_bias_row_range: assert property (@(posedge clk_i) disable iff (rst_i)
    bias_we_i |-> (int'(bias_row_i) < `GEMM_WIDTH));

endmodule

`default_nettype wire

//--- hdl/gemm_z_drain.sv
/* Result drain. After a start pulse it registers one accumulator row per cycle
   onto the Z port, flags the last row and raises the job event. */
`timescale 1ns/1ps
`default_nettype none

`include "gemm_params.svh"

module gemm_z_drain (
  input  logic                                                clk_i,
  input  logic                                                rst_i,
  input  logic                                                drain_start_i,
  input  gemm_pkg::acc_t  [`GEMM_WIDTH-1:0][`GEMM_HEIGHT-1:0] acc_i,
  output logic                                                z_valid_o,
  output gemm_pkg::acc_t  [`GEMM_HEIGHT-1:0]                  z_row_o,
  output logic                                                drain_done_o,
  output logic                                                evt_o
);

  localparam int ROW_W = `GEMM_ROW_W;
  localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`GEMM_WIDTH - 1);

  logic             active_q;
  logic [ROW_W-1:0] row_q;
  logic [ROW_W-1:0] sel_row;
  logic             issue;

  // Row 0 goes out right off the start pulse
  assign issue   = drain_start_i | active_q;
  assign sel_row = drain_start_i ? '0 : row_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q     <= 1'b0;
      row_q        <= '0;
      z_valid_o    <= 1'b0;
      drain_done_o <= 1'b0;
      evt_o        <= 1'b0;
    end else begin
      z_valid_o    <= issue;
      drain_done_o <= issue & (sel_row == LAST_ROW);
      evt_o        <= drain_done_o;
      if (issue) begin
        row_q    <= sel_row + 1'b1;
        active_q <= (sel_row != LAST_ROW);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      z_row_o <= acc_i[sel_row];
    end
  end

  // Scheduler never restarts the drain mid-stream
  a_no_restart: assert property (@(posedge clk_i) disable iff (rst_i)
    drain_start_i |-> !active_q);

endmodule

`default_nettype wire

//--- hdl/gemm_top.sv
/* Top level of the integer GEMM accelerator. Connects the register decoder and
   scheduler, the accumulator grid and the Z drain. */
`timescale 1ns/1ps
`default_nettype none

`include "gemm_params.svh"

module gemm_top (
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Control register port
  input  logic                               ctrl_req_i,
  input  logic                               ctrl_we_i,
  input  logic [`GEMM_ADDR_W-1:0]            ctrl_addr_i,
  input  logic [`GEMM_DATA_W-1:0]            ctrl_wdata_i,
  output logic [`GEMM_DATA_W-1:0]            ctrl_rdata_o,
  output logic                               ctrl_rvalid_o,
  // Operand strobes
  input  logic                               y_valid_i,
  input  gemm_pkg::elem_t [`GEMM_HEIGHT-1:0] y_row_i,
  input  logic                               x_valid_i,
  input  gemm_pkg::elem_t [`GEMM_WIDTH-1:0]  x_vec_i,
  input  gemm_pkg::elem_t [`GEMM_HEIGHT-1:0] w_vec_i,
  // Results and status
  output logic                               z_valid_o,
  output gemm_pkg::acc_t  [`GEMM_HEIGHT-1:0] z_row_o,
  output logic                               busy_o,
  output logic                               evt_o
);

  logic                                               bias_we;
  logic [`GEMM_ROW_W-1:0]                             bias_row;
  logic                                               mac_en;
  logic                                               drain_start;
  logic                                               drain_done;
  gemm_pkg::acc_t [`GEMM_WIDTH-1:0][`GEMM_HEIGHT-1:0] acc;

  gemm_cfg_decoder i_cfg_decoder (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .ctrl_req_i    ( ctrl_req_i    ),
    .ctrl_we_i     ( ctrl_we_i     ),
    .ctrl_addr_i   ( ctrl_addr_i   ),
    .ctrl_wdata_i  ( ctrl_wdata_i  ),
    .ctrl_rdata_o  ( ctrl_rdata_o  ),
    .ctrl_rvalid_o ( ctrl_rvalid_o ),
    .y_valid_i     ( y_valid_i     ),
    .x_valid_i     ( x_valid_i     ),
    .drain_done_i  ( drain_done    ),
    .bias_we_o     ( bias_we       ),
    .bias_row_o    ( bias_row      ),
    .mac_en_o      ( mac_en        ),
    .drain_start_o ( drain_start   ),
    .busy_o        ( busy_o        )
  );

  gemm_mac_array i_mac_array (
    .clk_i      ( clk_i    ),
    .rst_i      ( rst_i    ),
    .bias_we_i  ( bias_we  ),
    .bias_row_i ( bias_row ),
    .y_row_i    ( y_row_i  ),
    .mac_en_i   ( mac_en   ),
    .x_vec_i    ( x_vec_i  ),
    .w_vec_i    ( w_vec_i  ),
    .acc_o      ( acc      )
  );

  gemm_z_drain i_z_drain (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .drain_start_i ( drain_start ),
    .acc_i         ( acc         ),
    .z_valid_o     ( z_valid_o   ),
    .z_row_o       ( z_row_o     ),
    .drain_done_o  ( drain_done  ),
    .evt_o         ( evt_o       )
  );

endmodule

`default_nettype wire

//--- verification/gemm_tb.sv
/* Random-stimulus testbench for the GEMM accelerator top level. Runs jobs with
   random operands and gaps and checks every Z row against a software model. */
`timescale 1ns/1ps
`default_nettype none

`include "gemm_params.svh"

module gemm_tb;

  localparam int W = `GEMM_WIDTH;
  localparam int H = `GEMM_HEIGHT;
  localparam int GAP_MAX = 3;
  localparam int RAND_JOBS = 8;
  localparam int ZERO_JOBS = 2;
  localparam int BUSY_JOBS = 4;
  localparam int NUM_JOBS = RAND_JOBS + ZERO_JOBS + BUSY_JOBS;
  // Longest job has every row and beat behind a full gap, then drain and register traffic
  localparam int JOB_CYCLES = (W + 255) * (GAP_MAX + 1) + 2 * W + 40;
  localparam int WATCHDOG_NS = (NUM_JOBS * JOB_CYCLES + 200) * 10;

  logic                    clk_i;
  logic                    rst_i;
  logic                    ctrl_req_i;
  logic                    ctrl_we_i;
  logic [`GEMM_ADDR_W-1:0] ctrl_addr_i;
  logic [`GEMM_DATA_W-1:0] ctrl_wdata_i;
  logic [`GEMM_DATA_W-1:0] ctrl_rdata_o;
  logic                    ctrl_rvalid_o;
  logic                    y_valid_i;
  logic                    x_valid_i;
  gemm_pkg::elem_t [H-1:0] y_row_i;
  gemm_pkg::elem_t [W-1:0] x_vec_i;
  gemm_pkg::elem_t [H-1:0] w_vec_i;
  logic                    z_valid_o;
  gemm_pkg::acc_t  [H-1:0] z_row_o;
  logic                    busy_o;
  logic                    evt_o;

  // Reference Z of the running job
  int zm [W][H];
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int jobs_done = 0;
  int evt_count = 0;

  gemm_top uut (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if (evt_o) begin
      evt_count++;
    end
  end

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] status_word(input logic busy, input int count);
    return {16'd0, 8'(count), 7'd0, busy};
  endfunction

  task automatic ctrl_write(input logic [`GEMM_ADDR_W-1:0] addr, input logic [31:0] data);
    step();
    ctrl_req_i = 1'b1;
    ctrl_we_i = 1'b1;
    ctrl_addr_i = addr;
    ctrl_wdata_i = data;
    step();
    ctrl_req_i = 1'b0;
    ctrl_we_i = 1'b0;
  endtask

  // rvalid has to show up exactly one cycle after the request
  task automatic status_read(input logic [31:0] exp);
    step();
    ctrl_req_i = 1'b1;
    ctrl_we_i = 1'b0;
    ctrl_addr_i = `GEMM_REG_STATUS;
    @(negedge clk_i);
    check(32'(ctrl_rvalid_o), 32'd0, "rvalid in request cycle");
    step();
    ctrl_req_i = 1'b0;
    @(negedge clk_i);
    check(32'(ctrl_rvalid_o), 32'd1, "rvalid one cycle after request");
    check(ctrl_rdata_o, exp, "status word");
    step();
    @(negedge clk_i);
    check(32'(ctrl_rvalid_o), 32'd0, "rvalid two cycles after request");
  endtask

  task automatic rand_operands();
    for (int c = 0; c < H; c++) begin
      y_row_i[c] = 8'($urandom);
      w_vec_i[c] = 8'($urandom);
    end
    for (int r = 0; r < W; r++) begin
      x_vec_i[r] = 8'($urandom);
    end
  endtask

  task automatic run_job(input int k, input bit busy_ops);
    int gap;
    int wait_cycles;
    ctrl_write(`GEMM_REG_K, 32'(k));
    ctrl_write(`GEMM_REG_TRIG, 32'd0);
    check(32'(busy_o), 32'd1, "busy_o after trigger");
    if (busy_ops) begin
      status_read(status_word(1'b1, jobs_done));
      ctrl_write(`GEMM_REG_K, 32'(k + 7));
      ctrl_write(`GEMM_REG_TRIG, 32'd1);
    end
    // Bias rows with stray X strobes that must be ignored
    for (int r = 0; r < W; r++) begin
      gap = $urandom_range(0, GAP_MAX);
      for (int g = 0; g <= gap; g++) begin
        step();
        rand_operands();
        y_valid_i = (g == gap);
        x_valid_i = 1'($urandom_range(0, 1));
      end
      for (int c = 0; c < H; c++) begin
        zm[r][c] = int'(y_row_i[c]);
      end
    end
    // Outer products with stray Y strobes
    for (int b = 0; b < k; b++) begin
      gap = $urandom_range(0, GAP_MAX);
      for (int g = 0; g <= gap; g++) begin
        step();
        rand_operands();
        x_valid_i = (g == gap);
        y_valid_i = 1'($urandom_range(0, 1));
      end
      for (int r = 0; r < W; r++) begin
        for (int c = 0; c < H; c++) begin
          zm[r][c] += int'(x_vec_i[r]) * int'(w_vec_i[c]);
        end
      end
    end
    step();
    y_valid_i = 1'b0;
    x_valid_i = 1'b0;
    wait_cycles = 0;
    @(negedge clk_i);
    while (!z_valid_o && wait_cycles < 8) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    if (!z_valid_o) begin
      $display("z_valid_o did not rise within 8 cycles after the last beat at %0t", $time);
      errors++;
    end else begin
      for (int r = 0; r < W; r++) begin
        check(32'(z_valid_o), 32'd1, $sformatf("z_valid_o on row %0d", r));
        check(32'(evt_o), 32'd0, "evt_o during drain");
        check(32'(busy_o), 32'd1, "busy_o during drain");
        for (int c = 0; c < H; c++) begin
          check(z_row_o[c], 32'(zm[r][c]), $sformatf("Z[%0d][%0d]", r, c));
        end
        @(negedge clk_i);
      end
      check(32'(z_valid_o), 32'd0, "z_valid_o after last row");
      check(32'(evt_o), 32'd1, "evt_o after last row");
      check(32'(busy_o), 32'd0, "busy_o after last row");
      @(negedge clk_i);
      check(32'(evt_o), 32'd0, "evt_o one cycle later");
    end
    jobs_done++;
    check(32'(evt_count), 32'(jobs_done), "event count");
    status_read(status_word(1'b0, jobs_done));
  endtask

  task automatic report(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
    end
  endtask

  initial begin
    int errs_before;
    void'($urandom(32'ha70a_3b35));
    rst_i = 1'b1;
    ctrl_req_i = 1'b0;
    ctrl_we_i = 1'b0;
    ctrl_addr_i = '0;
    ctrl_wdata_i = '0;
    y_valid_i = 1'b0;
    x_valid_i = 1'b0;
    y_row_i = '0;
    x_vec_i = '0;
    w_vec_i = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    errs_before = errors;
    @(negedge clk_i);
    check(32'(busy_o), 32'd0, "busy_o after reset");
    check(32'(evt_o), 32'd0, "evt_o after reset");
    check(32'(z_valid_o), 32'd0, "z_valid_o after reset");
    status_read(32'd0);
    report("reset status", errs_before);

    errs_before = errors;
    for (int j = 0; j < RAND_JOBS; j++) begin
      run_job($urandom_range(1, 255), 1'b0);
    end
    report("random jobs", errs_before);

    errs_before = errors;
    for (int j = 0; j < ZERO_JOBS; j++) begin
      run_job(0, 1'b0);
    end
    report("zero depth", errs_before);

    errs_before = errors;
    for (int j = 0; j < BUSY_JOBS; j++) begin
      run_job($urandom_range(0, 255), 1'b1);
    end
    report("register access while busy", errs_before);

    errs_before = errors;
    check(32'(evt_count), 32'(NUM_JOBS), "total events");
    status_read(status_word(1'b0, NUM_JOBS));
    report("event and job count", errs_before);

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Stops a hung run
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/gemm_pkg.sv
hdl/gemm_cfg_decoder.sv
hdl/gemm_mac_array.sv
hdl/gemm_z_drain.sv
hdl/gemm_top.sv
verification/gemm_tb.sv

//--- Makefile
# Verilator build and run of the GEMM accelerator testbench
VERILATOR ?= verilator
TOP       ?= gemm_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
